/* issue_core_patterns.txt */
// func opa opa_tag opa_rdy opb opb_tag opb_rdy dest rd_mem wr_mem expected stall
// stall: 0 cdb_ready high, 1 random cdb_ready, 2 cdb_ready low until the station fills
// producer held on the cdb, eight waiters fill the station, a ninth finds it full
0 00000100 00 1 00000023 00 1 01 0 0 00000123 2
0 00000000 01 0 00000010 00 1 02 0 0 00000133 2
1 00001000 00 1 00000000 01 0 03 0 0 00000edd 2
2 00000000 01 0 00000000 01 0 04 0 0 00000123 2
3 00000000 01 0 0000f000 00 1 05 0 0 0000f123 2
4 00000000 01 0 0000ffff 00 1 06 0 0 0000fedc 2
5 00000001 00 1 00000000 01 0 07 0 0 00000008 2
6 00000000 01 0 00000004 00 1 08 0 0 00000012 2
7 00000000 01 0 00000200 00 1 09 0 0 00000001 2
0 00000007 00 1 00000009 00 1 0a 0 0 00000010 2
// independent, every function plus address ops
0 11111111 00 1 22222222 00 1 0b 0 0 33333333 0
1 00000005 00 1 00000007 00 1 0c 0 0 fffffffe 0
2 f0f0f0f0 00 1 3c3c3c3c 00 1 0d 0 0 30303030 0
3 0f000000 00 1 000000f0 00 1 0e 0 0 0f0000f0 0
4 aaaa5555 00 1 ffff0000 00 1 0f 0 0 55555555 0
5 00000003 00 1 00000024 00 1 10 0 0 00000030 0
6 80000000 00 1 0000001f 00 1 11 0 0 00000001 0
7 ffffffff 00 1 00000001 00 1 12 0 0 00000001 0
7 00000005 00 1 fffffff0 00 1 13 0 0 00000000 0
1 00001000 00 1 00000024 00 1 14 1 0 00001024 0
4 00002000 00 1 00000008 00 1 15 0 1 00002008 0
// dependency chain through the cdb
0 00000040 00 1 00000002 00 1 16 0 0 00000042 0
1 00000000 16 0 00000010 00 1 17 0 0 00000032 0
3 00000000 17 0 00000000 16 0 18 0 0 00000072 0
2 00000000 18 0 00000100 00 1 19 1 0 00000172 0
// independent under random cdb stalls
0 ffffffff 00 1 00000001 00 1 1a 0 0 00000000 1
4 12345678 00 1 0f0f0f0f 00 1 1b 0 0 1d3b5977 1
0 00003000 00 1 fffffffc 00 1 1c 0 1 00002ffc 1
1 00000100 00 1 00000001 00 1 1d 0 0 000000ff 1
6 f0000000 00 1 00000008 00 1 1e 0 0 00f00000 1
2 12345678 00 1 0000ffff 00 1 1f 0 0 00005678 1

/* verilog.f */
+incdir+.
ooo_pkg.sv
reservation_station.sv
stage_is.sv
alu_fu.sv
issue_core.sv
tb_issue_core.sv

/* run.sh */
#!/bin/sh
# compile and run the issue_core testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f verilog.f --top-module tb_issue_core -o tb_issue_core
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/tb_issue_core > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Test completed successfully" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* tb_issue_core.sv */
`timescale 1ns/10ps
`include "ooo_config.svh"

module tb_issue_core import ooo_pkg::*; ();

    // pattern file geometry, one line per instruction
    localparam int num_pats   = 31;
    localparam int num_fields = 12;

    logic              clock;
    logic              rst;
    logic              dispatch_valid;
    dispatch_packet_t  dispatch_packet;
    logic              dispatch_ready;
    logic              cdb_valid;
    cdb_packet_t       cdb_packet;
    logic              cdb_ready;

    logic [31:0]       pat_mem [num_pats*num_fields];
    int                line_of_tag [32];
    logic              seen [32];
    int                received_count;
    logic [1:0]        stall_mode;
    logic              full_seen;
    logic              held_valid;
    cdb_packet_t       held_pkt;
    integer            seed;

    issue_core i_issue_core (
        .clock           (clock),
        .rst             (rst),
        .dispatch_valid  (dispatch_valid),
        .dispatch_packet (dispatch_packet),
        .dispatch_ready  (dispatch_ready),
        .cdb_valid       (cdb_valid),
        .cdb_packet      (cdb_packet),
        .cdb_ready       (cdb_ready)
    );

    always #2 clock = ~clock;

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // columns: func opa opa_tag opa_rdy opb opb_tag opb_rdy dest rd wr expected stall
    function automatic dispatch_packet_t line_packet(input int n);
        dispatch_packet_t p;
        int b;
        b = n * num_fields;
        p.alu_func  = alu_func_t'(pat_mem[b][3:0]);
        p.opa_value = pat_mem[b+1];
        p.opa_tag   = pat_mem[b+2][`TAG_W-1:0];
        p.opa_ready = pat_mem[b+3][0];
        p.opb_value = pat_mem[b+4];
        p.opb_tag   = pat_mem[b+5][`TAG_W-1:0];
        p.opb_ready = pat_mem[b+6][0];
        p.dest_tag  = pat_mem[b+7][`TAG_W-1:0];
        // npc only rides along, any distinct value will do
        p.npc       = 32'h1000 + 32'(n * 4);
        p.rd_mem    = pat_mem[b+8][0];
        p.wr_mem    = pat_mem[b+9][0];
        return p;
    endfunction

    ////////////////////
    // cdb back-pressure
    ////////////////////

    // 0 always ready, 1 random stalls, 2 held low
    always @(posedge clock) begin
        if (rst) begin
            cdb_ready <= 1'b1;
        end else if (stall_mode == 2'd1) begin
            cdb_ready <= (($random(seed) & 3) != 0);
        end else if (stall_mode == 2'd2) begin
            cdb_ready <= 1'b0;
        end else begin
            cdb_ready <= 1'b1;
        end
    end

    ////////////////////
    // cdb monitor
    ////////////////////

    always @(posedge clock) begin
        int n;
        if (!rst) begin
            // a stalled broadcast must still be there, unchanged
            if (held_valid) begin
                check_value("cdb_valid_held", 64'd1, 64'(cdb_valid));
                check_value("cdb_packet_held", 64'(held_pkt), 64'(cdb_packet));
            end
            if (cdb_valid && cdb_ready) begin
                n = line_of_tag[cdb_packet.tag];
                check_value("result_tag_dispatched", 64'd1, 64'(n >= 0));
                check_value($sformatf("duplicate_tag_%0d", cdb_packet.tag), 64'd0,
                            64'(seen[cdb_packet.tag]));
                check_value($sformatf("result_tag_%0d", cdb_packet.tag),
                            64'(pat_mem[n*num_fields+10]), 64'(cdb_packet.value));
                check_value($sformatf("rd_mem_tag_%0d", cdb_packet.tag),
                            64'(pat_mem[n*num_fields+8][0]), 64'(cdb_packet.rd_mem));
                check_value($sformatf("wr_mem_tag_%0d", cdb_packet.tag),
                            64'(pat_mem[n*num_fields+9][0]), 64'(cdb_packet.wr_mem));
                seen[cdb_packet.tag] = 1'b1;
                received_count++;
            end
            held_valid = cdb_valid && !cdb_ready;
            held_pkt   = cdb_packet;
        end
    end

    ////////////////////
    // reset, dispatch and final checks
    ////////////////////

    initial begin
        int low_cycles;
        int tag;
        clock           = 1'b0;
        rst             = 1'b1;
        dispatch_valid  = 1'b0;
        dispatch_packet = '0;
        cdb_ready       = 1'b1;
        stall_mode      = 2'd0;
        full_seen       = 1'b0;
        held_valid      = 1'b0;
        held_pkt        = '0;
        received_count  = 0;
        seed            = 32'h88b1_46bc;
        for (int t = 0; t < 32; t++) begin
            line_of_tag[t] = -1;
            seen[t]        = 1'b0;
        end
        $readmemh("issue_core_patterns.txt", pat_mem);
        // results are matched by dest tag, so each tag once only
        for (int n = 0; n < num_pats; n++) begin
            tag = int'(pat_mem[n*num_fields+7][`TAG_W-1:0]);
            if (line_of_tag[tag] != -1) begin
                $display("pattern file uses dest tag %0d on more than one line", tag);
                $display("Test failed");
                $fatal(1, "bad pattern file");
            end
            line_of_tag[tag] = n;
        end
        repeat (8) @(posedge clock);
        rst <= 1'b0;
        @(posedge clock);
        check_value("dispatch_ready_after_reset", 64'd1, 64'(dispatch_ready));
        check_value("cdb_valid_after_reset", 64'd0, 64'(cdb_valid));

        for (int n = 0; n < num_pats; n++) begin
            dispatch_valid  <= 1'b1;
            dispatch_packet <= line_packet(n);
            stall_mode      <= pat_mem[n*num_fields+11][1:0];
            low_cycles = 0;
            @(posedge clock);
            while (!dispatch_ready) begin
                low_cycles++;
                // station full behind the held producer, so let it broadcast
                if (stall_mode == 2'd2 && low_cycles == 4) begin
                    check_value("lines_before_full", 64'(`RS_SIZE + 1), 64'(n));
                    full_seen = 1'b1;
                    stall_mode <= 2'd0;
                end
                @(posedge clock);
            end
        end
        dispatch_valid <= 1'b0;

        wait (received_count == num_pats);
        // a few idle cycles so a late duplicate would still show
        repeat (4) @(posedge clock);
        check_value("station_filled", 64'd1, 64'(full_seen));
        $display("Test completed successfully");
        $finish;
    end

    // 40 cycles per pattern line plus the reset
    initial begin
        repeat (num_pats * 40 + 8) @(posedge clock);
        $display("results did not arrive within 40 cycles per pattern line");
        $display("Test failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

/* issue_core.sv */
`timescale 1ns/10ps
`include "ooo_config.svh"

module issue_core import ooo_pkg::*; (
    input  logic              clock,
    input  logic              rst,

    input  logic              dispatch_valid,
    input  dispatch_packet_t  dispatch_packet,
    output logic              dispatch_ready,

    output logic              cdb_valid,
    output cdb_packet_t       cdb_packet,
    input  logic              cdb_ready
);

    ////////////////////
    // internal links
    ////////////////////

    rs_is_packet_t        rs_is_packet;
    logic [`RS_SIZE-1:0]  rs_issue_enable;
    logic                 fu_ready;
    logic                 issue_valid;
    is_ex_packet_t        is_packet;

    // station, also snoops the CDB it drives out
    reservation_station i_reservation_station (
        .clock           (clock),
        .rst             (rst),
        .dispatch_valid  (dispatch_valid),
        .dispatch_packet (dispatch_packet),
        .dispatch_ready  (dispatch_ready),
        .rs_issue_enable (rs_issue_enable),
        .cdb_valid       (cdb_valid),
        .cdb_ready       (cdb_ready),
        .cdb_packet      (cdb_packet),
        .rs_is_packet    (rs_is_packet)
    );

    // grant logic for the single ALU
    stage_is i_stage_is (
        .clock           (clock),
        .rst             (rst),
        .rs_is_packet    (rs_is_packet),
        .fu_ready        (fu_ready),
        .issue_valid     (issue_valid),
        .is_packet       (is_packet),
        .rs_issue_enable (rs_issue_enable)
    );

    alu_fu i_alu_fu (
        .clock       (clock),
        .rst         (rst),
        .issue_valid (issue_valid),
        .is_packet   (is_packet),
        .fu_ready    (fu_ready),
        .cdb_valid   (cdb_valid),
        .cdb_packet  (cdb_packet),
        .cdb_ready   (cdb_ready)
    );

endmodule

/* alu_fu.sv */
`timescale 1ns/10ps
`include "ooo_config.svh"

module alu_fu import ooo_pkg::*; (
    input  logic           clock,
    input  logic           rst,

    // from the issue stage
    input  logic           issue_valid,
    input  is_ex_packet_t  is_packet,
    output logic           fu_ready,

    // CDB, valid/ready
    output logic           cdb_valid,
    output cdb_packet_t    cdb_packet,
    input  logic           cdb_ready
);

    logic              s1_valid;
    is_ex_packet_t     s1_pkt;
    logic              out_stall;
    logic [`XLEN-1:0]  result;

    // output register full and not taken
    assign out_stall = cdb_valid && !cdb_ready;
    // stage 1 can take more if empty or moving on
    assign fu_ready  = !s1_valid || !out_stall;

    ////////////////////
    // stage 1, operand register
    ////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (fu_ready) begin
            s1_valid <= issue_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (fu_ready && issue_valid) begin
            s1_pkt <= is_packet;
        end
    end

    ////////////////////
    // stage 2, compute into output register
    ////////////////////

    always_comb begin
        case (s1_pkt.alu_func)
            alu_add: result = s1_pkt.opa + s1_pkt.opb;
            alu_sub: result = s1_pkt.opa - s1_pkt.opb;
            alu_and: result = s1_pkt.opa & s1_pkt.opb;
            alu_or:  result = s1_pkt.opa | s1_pkt.opb;
            alu_xor: result = s1_pkt.opa ^ s1_pkt.opb;
            // shift amount from the low 5 bits only
            alu_sll: result = s1_pkt.opa << s1_pkt.opb[4:0];
            alu_srl: result = s1_pkt.opa >> s1_pkt.opb[4:0];
            alu_slt: result = {{(`XLEN-1){1'b0}},
                               $signed(s1_pkt.opa) < $signed(s1_pkt.opb)};
            default: result = '0;
        endcase
        // memory ops only need the effective address
        if (s1_pkt.rd_mem || s1_pkt.wr_mem) begin
            result = s1_pkt.opa + s1_pkt.opb;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else if (!out_stall) begin
            cdb_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (!out_stall && s1_valid) begin
            cdb_packet.tag    <= s1_pkt.rob_tag;
            cdb_packet.value  <= result;
            cdb_packet.rd_mem <= s1_pkt.rd_mem;
            cdb_packet.wr_mem <= s1_pkt.wr_mem;
        end
    end

    // an issue while stage 1 holds would be lost
    a_issue_when_ready: assert property (
        @(posedge clock) disable iff (rst) issue_valid |-> fu_ready
    );

endmodule

/* stage_is.sv */
`timescale 1ns/10ps
`include "ooo_config.svh"

module stage_is import ooo_pkg::*; (
    input  logic                 clock,
    input  logic                 rst,

    // entry view from the station
    input  rs_is_packet_t        rs_is_packet,

    // ALU can take a new instruction
    input  logic                 fu_ready,

    output logic                 issue_valid,
    output is_ex_packet_t        is_packet,

    // grant back to the station, frees the entry at the edge
    output logic [`RS_SIZE-1:0]  rs_issue_enable
);

    logic picked;

    // fixed priority, lowest index first
    always_comb begin
        picked          = 1'b0;
        issue_valid     = 1'b0;
        is_packet       = '0;
        rs_issue_enable = '0;
        if (fu_ready) begin
            for (int i = 0; i < `RS_SIZE; i++) begin
                if (!picked && rs_is_packet.rs_ready_out[i]) begin
                    picked                = 1'b1;
                    issue_valid           = 1'b1;
                    is_packet.opa         = rs_is_packet.rs_opa_out[i];
                    is_packet.opb         = rs_is_packet.rs_opb_out[i];
                    is_packet.rob_tag     = rs_is_packet.rs_tag_out[i];
                    is_packet.issue_valid = 1'b1;
                    is_packet.alu_func    = rs_is_packet.rs_alu_func_out[i];
                    is_packet.npc         = rs_is_packet.rs_npc_out[i];
                    // entry index, for debug and tracking
                    is_packet.rs_tag      = (`RS_IDX_W)'(i);
                    is_packet.rd_mem      = rs_is_packet.rs_rd_mem[i];
                    is_packet.wr_mem      = rs_is_packet.rs_wr_mem[i];
                    rs_issue_enable[i]    = 1'b1;
                end
            end
        end
    end

    // a granted entry is gone from the ready set by the next cycle
    a_grant_released: assert property (
        @(posedge clock) disable iff (rst)
        issue_valid |=> (rs_is_packet.rs_ready_out & $past(rs_issue_enable)) == '0
    );

endmodule

/* reservation_station.sv */
`timescale 1ns/10ps
`include "ooo_config.svh"

module reservation_station import ooo_pkg::*; (
    input  logic                 clock,
    input  logic                 rst,

    // dispatch port, valid/ready
    input  logic                 dispatch_valid,
    input  dispatch_packet_t     dispatch_packet,
    output logic                 dispatch_ready,

    // one-hot grant from the issue stage, frees that entry
    input  logic [`RS_SIZE-1:0]  rs_issue_enable,

    // CDB snoop for operand wake-up
    input  logic                 cdb_valid,
    input  logic                 cdb_ready,
    input  cdb_packet_t          cdb_packet,

    output rs_is_packet_t        rs_is_packet
);

    logic [`RS_SIZE-1:0]  busy;
    dispatch_packet_t     entry [`RS_SIZE];
    logic [`RS_SIZE-1:0]  alloc_onehot;
    logic                 dispatch_fire;
    logic                 cdb_fire;
    dispatch_packet_t     dispatch_woken;

    ////////////////////
    // allocation
    ////////////////////

    // lowest free entry wins
    always_comb begin
        alloc_onehot = '0;
        for (int i = 0; i < `RS_SIZE; i++) begin
            if (!busy[i] && alloc_onehot == '0) begin
                alloc_onehot[i] = 1'b1;
            end
        end
    end

    assign dispatch_ready = |(~busy);
    assign dispatch_fire  = dispatch_valid && dispatch_ready;
    // wake-up only counts on an accepted broadcast
    assign cdb_fire       = cdb_valid && cdb_ready;

    // a producer may broadcast in the very cycle its consumer is dispatched,
    // so catch the value on the way in as well
    always_comb begin
        dispatch_woken = dispatch_packet;
        if (cdb_fire && !dispatch_packet.opa_ready &&
            dispatch_packet.opa_tag == cdb_packet.tag) begin
            dispatch_woken.opa_value = cdb_packet.value;
            dispatch_woken.opa_ready = 1'b1;
        end
        if (cdb_fire && !dispatch_packet.opb_ready &&
            dispatch_packet.opb_tag == cdb_packet.tag) begin
            dispatch_woken.opb_value = cdb_packet.value;
            dispatch_woken.opb_ready = 1'b1;
        end
    end

    // busy set on allocation, cleared on issue
    always_ff @(posedge clock) begin
        if (rst) begin
            busy <= '0;
        end else begin
            busy <= (busy & ~rs_issue_enable) | (dispatch_fire ? alloc_onehot : '0);
        end
    end

    ////////////////////
    // entry storage and wake-up
    ////////////////////

    always_ff @(posedge clock) begin
        for (int i = 0; i < `RS_SIZE; i++) begin
            if (dispatch_fire && alloc_onehot[i]) begin
                entry[i] <= dispatch_woken;
            end else begin
                // waiting operand grabs a matching broadcast
                if (cdb_fire && busy[i] && !entry[i].opa_ready &&
                    entry[i].opa_tag == cdb_packet.tag) begin
                    entry[i].opa_value <= cdb_packet.value;
                    entry[i].opa_ready <= 1'b1;
                end
                if (cdb_fire && busy[i] && !entry[i].opb_ready &&
                    entry[i].opb_tag == cdb_packet.tag) begin
                    entry[i].opb_value <= cdb_packet.value;
                    entry[i].opb_ready <= 1'b1;
                end
            end
        end
    end

    // ready means busy with both operands in hand
    always_comb begin
        for (int i = 0; i < `RS_SIZE; i++) begin
            rs_is_packet.rs_ready_out[i] = busy[i] && entry[i].opa_ready &&
                                           entry[i].opb_ready;
            rs_is_packet.rs_opa_out[i]      = entry[i].opa_value;
            rs_is_packet.rs_opb_out[i]      = entry[i].opb_value;
            rs_is_packet.rs_tag_out[i]      = entry[i].dest_tag;
            rs_is_packet.rs_alu_func_out[i] = entry[i].alu_func;
            rs_is_packet.rs_npc_out[i]      = entry[i].npc;
            rs_is_packet.rs_rd_mem[i]       = entry[i].rd_mem;
            rs_is_packet.rs_wr_mem[i]       = entry[i].wr_mem;
        end
    end

    ////////////////////
    // checks on the grant from the issue stage
    ////////////////////

    a_grant_onehot: assert property (
        @(posedge clock) disable iff (rst) $onehot0(rs_issue_enable)
    );

    a_grant_busy: assert property (
        @(posedge clock) disable iff (rst) (rs_issue_enable & ~busy) == '0
    );

endmodule

/* ooo_pkg.sv */
`include "ooo_config.svh"

package ooo_pkg;

    // ALU function select, 4 bits wide to leave room for more ops
    typedef enum logic [3:0] {
        alu_add = 4'h0,
        alu_sub = 4'h1,
        alu_and = 4'h2,
        alu_or  = 4'h3,
        alu_xor = 4'h4,
        alu_sll = 4'h5,
        alu_srl = 4'h6,
        alu_slt = 4'h7
    } alu_func_t;

    // one instruction as it arrives on the dispatch port
    // a *_ready bit low means the operand still waits on *_tag
    typedef struct packed {
        alu_func_t             alu_func;
        logic [`XLEN-1:0]      opa_value;
        logic [`TAG_W-1:0]     opa_tag;
        logic                  opa_ready;
        logic [`XLEN-1:0]      opb_value;
        logic [`TAG_W-1:0]     opb_tag;
        logic                  opb_ready;
        logic [`TAG_W-1:0]     dest_tag;
        logic [`XLEN-1:0]      npc;
        logic                  rd_mem;
        logic                  wr_mem;
    } dispatch_packet_t;

    // per entry view of the station, one slot per entry in each field
    typedef struct packed {
        logic [`RS_SIZE-1:0]                rs_ready_out;
        logic [`RS_SIZE-1:0][`XLEN-1:0]     rs_opa_out;
        logic [`RS_SIZE-1:0][`XLEN-1:0]     rs_opb_out;
        logic [`RS_SIZE-1:0][`TAG_W-1:0]    rs_tag_out;
        alu_func_t [`RS_SIZE-1:0]           rs_alu_func_out;
        logic [`RS_SIZE-1:0][`XLEN-1:0]     rs_npc_out;
        logic [`RS_SIZE-1:0]                rs_rd_mem;
        logic [`RS_SIZE-1:0]                rs_wr_mem;
    } rs_is_packet_t;

    // the one instruction picked for the ALU this cycle
    typedef struct packed {
        logic [`XLEN-1:0]      opa;
        logic [`XLEN-1:0]      opb;
        logic [`TAG_W-1:0]     rob_tag;
        logic                  issue_valid;
        alu_func_t             alu_func;
        logic [`XLEN-1:0]      npc;
        logic [`RS_IDX_W-1:0]  rs_tag;
        logic                  rd_mem;
        logic                  wr_mem;
    } is_ex_packet_t;

    // common data bus broadcast
    typedef struct packed {
        logic [`TAG_W-1:0]     tag;
        logic [`XLEN-1:0]      value;
        logic                  rd_mem;
        logic                  wr_mem;
    } cdb_packet_t;

endpackage

/* ooo_config.svh */
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

////////////////////
// reservation station sizing
////////////////////

// number of entries, all sharing the one ALU
`define RS_SIZE 8

// entry index width, must cover RS_SIZE
`define RS_IDX_W 3

////////////////////
// datapath widths
////////////////////

// reorder buffer tag, also the CDB tag
`define TAG_W 5

// operand and result width
`define XLEN 32

`endif
